// File: logic/gpio_settings.svh
`ifndef GPIO_SETTINGS_SVH
`define GPIO_SETTINGS_SVH

// Port and bus geometry
`define GPIO_WIDTH       8    // Pins per port
`define GPIO_BUS_WIDTH   16   // Peripheral data bus
`define GPIO_ADDR_WIDTH  14   // Word address
`define GPIO_DEC_WIDTH   5    // Word-address bits decoded locally

// Word map, base address is zero
`define GPIO_PORT_WORDS  4    // Words per port
`define GPIO_P1_WORD     'h10 // Byte offset 0x20
`define GPIO_P2_WORD     'h14 // Byte offset 0x28

// Word offsets inside one port
`define GPIO_WORD_IN_OUT   0  // IN low, OUT high
`define GPIO_WORD_DIR_IFG  1  // DIR low, IFG high
`define GPIO_WORD_IES_IE   2  // IES low, IE high
`define GPIO_WORD_SEL      3  // SEL low, high lane unused

`endif

// File: logic/gpio_pkg.sv
`default_nettype none

`include "gpio_settings.svh"

package gpio_pkg;

  // One port's view of a bus access
  typedef struct packed {
    logic [`GPIO_PORT_WORDS-1:0] word_sel; // One-hot word of the port
    logic                        wr_lo;    // Even byte write
    logic                        wr_hi;    // Odd byte write
    logic                        rd;
    logic [`GPIO_BUS_WIDTH-1:0]  wdata;
  } gpio_access_t;

  // Pad controls
  typedef struct packed {
    logic [`GPIO_WIDTH-1:0] dout;
    logic [`GPIO_WIDTH-1:0] dout_en;  // DIR, high drives the pad
    logic [`GPIO_WIDTH-1:0] sel;      // Peripheral function select
  } gpio_pad_t;

  // Synchronised pins and their one-cycle edge strobes
  typedef struct packed {
    logic [`GPIO_WIDTH-1:0] level;
    logic [`GPIO_WIDTH-1:0] rise;
    logic [`GPIO_WIDTH-1:0] fall;
  } gpio_edges_t;

endpackage

`default_nettype wire

// File: logic/gpio_reg_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "gpio_settings.svh"

module gpio_reg_decode import gpio_pkg::*; (
  input  wire logic [`GPIO_ADDR_WIDTH-1:0] per_addr,
  input  wire logic [`GPIO_BUS_WIDTH-1:0]  per_din,
  input  wire logic                        per_en,
  input  wire logic [1:0]                  per_we,
  output gpio_access_t                     p1_acc,
  output gpio_access_t                     p2_acc
);

  localparam int WSEL_BITS = $clog2(`GPIO_PORT_WORDS);
  localparam logic [`GPIO_DEC_WIDTH-1:0] P1_WORD = `GPIO_P1_WORD;
  localparam logic [`GPIO_DEC_WIDTH-1:0] P2_WORD = `GPIO_P2_WORD;

  logic                        reg_sel;
  logic [`GPIO_DEC_WIDTH-1:0]  reg_word;
  logic [`GPIO_PORT_WORDS-1:0] word_onehot;
  logic                        p1_hit;
  logic                        p2_hit;
  gpio_access_t                acc_any;

  // Strobes kept only for the port that was hit
  function automatic gpio_access_t gate_access(input gpio_access_t acc, input logic hit);
    gpio_access_t res;
    res          = acc;
    res.word_sel = acc.word_sel & {`GPIO_PORT_WORDS{hit}};
    res.wr_lo    = acc.wr_lo & hit;
    res.wr_hi    = acc.wr_hi & hit;
    res.rd       = acc.rd & hit;
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Address match
  ////////////////////////////////////////////////////////////////////////////

  assign reg_sel  = per_en & (per_addr[`GPIO_ADDR_WIDTH-1:`GPIO_DEC_WIDTH] == '0);
  assign reg_word = per_addr[`GPIO_DEC_WIDTH-1:0];

  assign word_onehot = {{(`GPIO_PORT_WORDS-1){1'b0}}, 1'b1} << reg_word[WSEL_BITS-1:0];

  assign p1_hit = reg_sel &
                  (reg_word[`GPIO_DEC_WIDTH-1:WSEL_BITS] == P1_WORD[`GPIO_DEC_WIDTH-1:WSEL_BITS]);
  assign p2_hit = reg_sel &
                  (reg_word[`GPIO_DEC_WIDTH-1:WSEL_BITS] == P2_WORD[`GPIO_DEC_WIDTH-1:WSEL_BITS]);

  always_comb begin
    acc_any.word_sel = word_onehot;
    acc_any.wr_lo    = per_we[0];
    acc_any.wr_hi    = per_we[1];
    acc_any.rd       = ~|per_we;  // No lane strobe means read
    acc_any.wdata    = per_din;
  end

  assign p1_acc = gate_access(acc_any, p1_hit);
  assign p2_acc = gate_access(acc_any, p2_hit);

endmodule

`default_nettype wire

// File: logic/gpio_pin_sampler.sv
`timescale 1ns/100ps
`default_nettype none

`include "gpio_settings.svh"

module gpio_pin_sampler import gpio_pkg::*; (
  input  wire logic                   mclk,
  input  wire logic                   puc_rst,
  input  wire logic [`GPIO_WIDTH-1:0] din,
  output gpio_edges_t                 pins
);

  logic [`GPIO_WIDTH-1:0] sync_meta;  // First stage, may go metastable
  logic [`GPIO_WIDTH-1:0] sync_level;
  logic [`GPIO_WIDTH-1:0] level_dly;

  ////////////////////////////////////////////////////////////////////////////
  // Two-flop synchroniser plus one delay stage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      sync_meta  <= '0;
      sync_level <= '0;
      level_dly  <= '0;
    end else begin
      sync_meta  <= din;
      sync_level <= sync_meta;
      level_dly  <= sync_level;
    end
  end

  // Edges last exactly one cycle
  assign pins.level = sync_level;
  assign pins.rise  = sync_level & ~level_dly;
  assign pins.fall  = ~sync_level & level_dly;

endmodule

`default_nettype wire

// File: logic/gpio_port.sv
`timescale 1ns/100ps
`default_nettype none

`include "gpio_settings.svh"

module gpio_port import gpio_pkg::*; (
  input  wire logic                       mclk,
  input  wire logic                       puc_rst,
  input  gpio_access_t                    acc,
  input  gpio_edges_t                     pins,
  output gpio_pad_t                       pad,
  output logic                            irq,
  output logic [`GPIO_BUS_WIDTH-1:0]      rdata
);

  localparam int W = `GPIO_WIDTH;

  logic [W-1:0] out;
  logic [W-1:0] dir;
  logic [W-1:0] ifg;
  logic [W-1:0] ies;
  logic [W-1:0] ie;
  logic [W-1:0] sel;

  logic         out_wr;
  logic         dir_wr;
  logic         ifg_wr;
  logic         ies_wr;
  logic         ie_wr;
  logic         sel_wr;
  logic [W-1:0] wdata_lo;
  logic [W-1:0] wdata_hi;
  logic [W-1:0] ifg_set;
  logic [W-1:0] rd_lo;
  logic [W-1:0] rd_hi;

  ////////////////////////////////////////////////////////////////////////////
  // Write strobes, one word and one lane per register
  ////////////////////////////////////////////////////////////////////////////

  assign wdata_lo = acc.wdata[W-1:0];
  assign wdata_hi = acc.wdata[2*W-1:W];

  assign out_wr = acc.word_sel[`GPIO_WORD_IN_OUT]  & acc.wr_hi;
  assign dir_wr = acc.word_sel[`GPIO_WORD_DIR_IFG] & acc.wr_lo;
  assign ifg_wr = acc.word_sel[`GPIO_WORD_DIR_IFG] & acc.wr_hi;
  assign ies_wr = acc.word_sel[`GPIO_WORD_IES_IE]  & acc.wr_lo;
  assign ie_wr  = acc.word_sel[`GPIO_WORD_IES_IE]  & acc.wr_hi;
  assign sel_wr = acc.word_sel[`GPIO_WORD_SEL]     & acc.wr_lo;

  // Configuration registers
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      out <= '0;
      dir <= '0;
      ies <= '0;
      ie  <= '0;
      sel <= '0;
    end else begin
      if (out_wr) out <= wdata_hi;
      if (dir_wr) dir <= wdata_lo;
      if (ies_wr) ies <= wdata_lo;
      if (ie_wr)  ie  <= wdata_hi;
      if (sel_wr) sel <= wdata_lo;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Interrupt flags
  ////////////////////////////////////////////////////////////////////////////

  // IES picks the edge per pin
  assign ifg_set = (ies & pins.fall) | (~ies & pins.rise);

  // A hardware set beats a clearing write in the same cycle
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      ifg <= '0;
    end else if (ifg_wr) begin
      ifg <= wdata_hi | ifg_set;
    end else begin
      ifg <= ifg | ifg_set;
    end
  end

  assign irq = |(ifg & ie);

  assign pad.dout    = out;
  assign pad.dout_en = dir;
  assign pad.sel     = sel;

  ////////////////////////////////////////////////////////////////////////////
  // Read-back
  ////////////////////////////////////////////////////////////////////////////

  assign rd_lo = ({W{acc.word_sel[`GPIO_WORD_IN_OUT]}}  & pins.level) |
                 ({W{acc.word_sel[`GPIO_WORD_DIR_IFG]}} & dir)        |
                 ({W{acc.word_sel[`GPIO_WORD_IES_IE]}}  & ies)        |
                 ({W{acc.word_sel[`GPIO_WORD_SEL]}}     & sel);

  // Word 3 high lane stays zero
  assign rd_hi = ({W{acc.word_sel[`GPIO_WORD_IN_OUT]}}  & out) |
                 ({W{acc.word_sel[`GPIO_WORD_DIR_IFG]}} & ifg) |
                 ({W{acc.word_sel[`GPIO_WORD_IES_IE]}}  & ie);

  assign rdata = acc.rd ? {rd_hi, rd_lo} : '0;

endmodule

`default_nettype wire

// File: logic/gpio_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "gpio_settings.svh"

module gpio_top import gpio_pkg::*; (
  input  wire logic                        mclk,
  input  wire logic                        puc_rst,
  input  wire logic [`GPIO_ADDR_WIDTH-1:0] per_addr,
  input  wire logic [`GPIO_BUS_WIDTH-1:0]  per_din,
  input  wire logic                        per_en,
  input  wire logic [1:0]                  per_we,
  input  wire logic [`GPIO_WIDTH-1:0]      p1_din,
  input  wire logic [`GPIO_WIDTH-1:0]      p2_din,
  output gpio_pad_t                        p1_pad,
  output gpio_pad_t                        p2_pad,
  output logic                             irq_port1,
  output logic                             irq_port2,
  output logic [`GPIO_BUS_WIDTH-1:0]       per_dout
);

  gpio_access_t                p1_acc;
  gpio_access_t                p2_acc;
  gpio_edges_t                 p1_pins;
  gpio_edges_t                 p2_pins;
  logic [`GPIO_BUS_WIDTH-1:0]  p1_rdata;
  logic [`GPIO_BUS_WIDTH-1:0]  p2_rdata;

  gpio_reg_decode u_decode (
    .per_addr (per_addr),
    .per_din  (per_din),
    .per_en   (per_en),
    .per_we   (per_we),
    .p1_acc   (p1_acc),
    .p2_acc   (p2_acc)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Port 1
  ////////////////////////////////////////////////////////////////////////////

  gpio_pin_sampler u_p1_sampler (.mclk(mclk), .puc_rst(puc_rst), .din(p1_din), .pins(p1_pins));

  gpio_port u_port1 (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .acc     (p1_acc),
    .pins    (p1_pins),
    .pad     (p1_pad),
    .irq     (irq_port1),
    .rdata   (p1_rdata)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Port 2
  ////////////////////////////////////////////////////////////////////////////

  gpio_pin_sampler u_p2_sampler (.mclk(mclk), .puc_rst(puc_rst), .din(p2_din), .pins(p2_pins));

  gpio_port u_port2 (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .acc     (p2_acc),
    .pins    (p2_pins),
    .pad     (p2_pad),
    .irq     (irq_port2),
    .rdata   (p2_rdata)
  );

  // Unselected ports return zero, so a plain OR is enough
  assign per_dout = p1_rdata | p2_rdata;

endmodule

`default_nettype wire

// File: bench/gpio_props.sv
`timescale 1ns/100ps
`default_nettype none

`include "gpio_settings.svh"

module gpio_props import gpio_pkg::*; (
  input wire logic                       mclk,
  input wire logic                       puc_rst,
  input wire logic                       per_en,
  input wire logic [`GPIO_BUS_WIDTH-1:0] per_dout,
  input wire gpio_pad_t                  p1_pad,
  input wire gpio_pad_t                  p2_pad,
  input wire logic                       irq_port1,
  input wire logic                       irq_port2,
  input wire logic [`GPIO_WIDTH-1:0]     p1_ifg,
  input wire logic [`GPIO_WIDTH-1:0]     p1_ie,
  input wire logic [`GPIO_WIDTH-1:0]     p2_ifg,
  input wire logic [`GPIO_WIDTH-1:0]     p2_ie
);

  // Outputs quiet in reset
  a_reset_quiet: assert property (@(posedge mclk) puc_rst |->
      (!irq_port1 && !irq_port2 && p1_pad == '0 && p2_pad == '0))
    else $error("irq or pad output active during reset");

  a_idle_dout: assert property (@(posedge mclk) !per_en |-> per_dout == '0)
    else $error("per_dout nonzero with per_en low");

  a_irq1: assert property (@(posedge mclk) disable iff (puc_rst)
      irq_port1 == |(p1_ifg & p1_ie))
    else $error("irq_port1 does not match IFG and IE");

  a_irq2: assert property (@(posedge mclk) disable iff (puc_rst)
      irq_port2 == |(p2_ifg & p2_ie))
    else $error("irq_port2 does not match IFG and IE");

endmodule

bind gpio_top gpio_props u_props (
  .mclk      (mclk),
  .puc_rst   (puc_rst),
  .per_en    (per_en),
  .per_dout  (per_dout),
  .p1_pad    (p1_pad),
  .p2_pad    (p2_pad),
  .irq_port1 (irq_port1),
  .irq_port2 (irq_port2),
  .p1_ifg    (u_port1.ifg),
  .p1_ie     (u_port1.ie),
  .p2_ifg    (u_port2.ifg),
  .p2_ie     (u_port2.ie)
);

`default_nettype wire

// File: bench/gpio_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "gpio_settings.svh"

module gpio_tb import gpio_pkg::*; ();

  localparam int W = `GPIO_WIDTH;

  // Bench copy of one port
  typedef struct packed {
    logic [W-1:0] out;
    logic [W-1:0] dir;
    logic [W-1:0] ifg;
    logic [W-1:0] ies;
    logic [W-1:0] ie;
    logic [W-1:0] sel;
    logic [W-1:0] meta;   // Pin pipe, first stage
    logic [W-1:0] level;  // What IN shows
    logic [W-1:0] dly;
  } port_model_t;

  logic                        mclk;
  logic                        puc_rst;
  logic [`GPIO_ADDR_WIDTH-1:0] per_addr;
  logic [`GPIO_BUS_WIDTH-1:0]  per_din;
  logic                        per_en;
  logic [1:0]                  per_we;
  logic [W-1:0]                p1_din;
  logic [W-1:0]                p2_din;
  gpio_pad_t                   p1_pad;
  gpio_pad_t                   p2_pad;
  logic                        irq_port1;
  logic                        irq_port2;
  logic [`GPIO_BUS_WIDTH-1:0]  per_dout;

  port_model_t model [2];
  int          hold [2];  // Cycles left before a pin change

  gpio_top u_dut (
    .mclk      (mclk),
    .puc_rst   (puc_rst),
    .per_addr  (per_addr),
    .per_din   (per_din),
    .per_en    (per_en),
    .per_we    (per_we),
    .p1_din    (p1_din),
    .p2_din    (p2_din),
    .p1_pad    (p1_pad),
    .p2_pad    (p2_pad),
    .irq_port1 (irq_port1),
    .irq_port2 (irq_port2),
    .per_dout  (per_dout)
  );

  initial begin
    mclk = 1'b0;
    forever #4 mclk = ~mclk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Model
  ////////////////////////////////////////////////////////////////////////////

  // Port 1 owns words 0x10..0x13, port 2 owns 0x14..0x17
  function automatic int port_index(input logic [`GPIO_ADDR_WIDTH-1:0] addr);
    int a;
    a = int'(addr);
    if (a >= 'h10 && a < 'h14) return 0;
    if (a >= 'h14 && a < 'h18) return 1;
    return -1;
  endfunction

  function automatic logic [15:0] expect_read();
    int           p;
    port_model_t  m;
    logic [15:0]  rd;
    p  = port_index(per_addr);
    rd = 16'h0000;
    if (per_en && per_we == 2'b00 && p >= 0) begin
      m = model[p];
      case (per_addr[1:0])
        2'd0:    rd = {m.out, m.level};
        2'd1:    rd = {m.ifg, m.dir};
        2'd2:    rd = {m.ie, m.ies};
        default: rd = {8'h00, m.sel};
      endcase
    end
    return rd;
  endfunction

  // One rising edge of mclk with the inputs now on the bus
  task automatic model_clock();
    int           p;
    port_model_t  m;
    logic [W-1:0] hw_set [2];
    for (int i = 0; i < 2; i++) begin
      m = model[i];
      hw_set[i] = (m.ies & ~m.level & m.dly) | (~m.ies & m.level & ~m.dly);
    end
    p = port_index(per_addr);
    if (per_en && p >= 0 && per_we != 2'b00) begin
      m = model[p];
      case (per_addr[1:0])
        2'd0: if (per_we[1]) m.out = per_din[15:8];  // IN is read-only
        2'd1: begin
          if (per_we[0]) m.dir = per_din[7:0];
          if (per_we[1]) m.ifg = per_din[15:8];
        end
        2'd2: begin
          if (per_we[0]) m.ies = per_din[7:0];
          if (per_we[1]) m.ie  = per_din[15:8];
        end
        default: if (per_we[0]) m.sel = per_din[7:0];
      endcase
      model[p] = m;
    end
    for (int i = 0; i < 2; i++) begin
      m       = model[i];
      m.ifg   = m.ifg | hw_set[i];  // Hardware set wins
      m.dly   = m.level;
      m.level = m.meta;
      m.meta  = (i == 0) ? p1_din : p2_din;
      model[i] = m;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks and bus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_outputs();
    check_value("per_dout", 32'(per_dout), 32'(expect_read()));
    check_value("p1_pad", 32'(p1_pad), 32'({model[0].out, model[0].dir, model[0].sel}));
    check_value("p2_pad", 32'(p2_pad), 32'({model[1].out, model[1].dir, model[1].sel}));
    check_value("irq_port1", 32'(irq_port1), 32'(|(model[0].ifg & model[0].ie)));
    check_value("irq_port2", 32'(irq_port2), 32'(|(model[1].ifg & model[1].ie)));
  endtask

  // Entered and left just after a falling edge
  task automatic cycle();
    #2;
    check_outputs();
    @(posedge mclk);
    model_clock();
    @(negedge mclk);
  endtask

  task automatic bus_access(input int addr, input logic [1:0] we, input logic [15:0] data);
    per_en   = 1'b1;
    per_addr = `GPIO_ADDR_WIDTH'(addr);
    per_we   = we;
    per_din  = data;
  endtask

  task automatic drive_random();
    int kind;
    kind = int'($urandom % 8);
    if (kind < 6) per_addr = 14'h10 + 14'($urandom % 8);
    else if (kind == 6) per_addr = 14'($urandom % 32);  // Unmapped words
    else per_addr = 14'($urandom);                        // Mostly out of base
    per_en  = (($urandom % 8) != 0);
    per_we  = (($urandom % 2) == 0) ? 2'b00 : 2'($urandom);
    per_din = 16'($urandom);
    for (int i = 0; i < 2; i++) begin
      if (hold[i] == 0) begin
        if (i == 0) p1_din = 8'($urandom);
        else p2_din = 8'($urandom);
        hold[i] = 3 + int'($urandom % 4);
      end else begin
        hold[i]--;
      end
    end
  endtask

  // Pin 0 first reads high on IN in the cycle its rise strobe is up
  task automatic wait_p1_pin0_rise();
    int n;
    n = 0;
    bus_access('h10, 2'b00, 16'h0000);  // Watch IN
    cycle();
    while (per_dout[0] !== 1'b1) begin
      if (n == 10) begin
        $display("Timed out waiting for a rising edge on port 1 pin 0");
        $display("Simulation failed");
        $fatal(1, "Timeout");
      end else begin
        cycle();
        n++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(76194));
    puc_rst  = 1'b0;
    per_addr = '0;
    per_din  = '0;
    per_en   = 1'b0;
    per_we   = 2'b00;
    p1_din   = '0;
    p2_din   = '0;
    model[0] = '0;
    model[1] = '0;
    hold[0]  = 0;
    hold[1]  = 0;
    #1 puc_rst = 1'b1;
    repeat (2) @(posedge mclk);
    @(negedge mclk);
    puc_rst = 1'b0;

    // Everything reads back as zero after reset
    for (int i = 0; i < 8; i++) begin
      bus_access('h10 + i, 2'b00, 16'h0000);
      #1;
      check_value("per_dout after reset", 32'(per_dout), 32'h0);
      cycle();
    end

    repeat (400) begin
      drive_random();
      cycle();
    end

    // Clear write against a rising edge on port 1 pin 0
    per_en = 1'b0;
    p1_din = 8'h00;
    repeat (3) cycle();  // Pin pipe is three deep
    bus_access('h12, 2'b11, 16'h0100);  // IES rising, IE on pin 0
    cycle();
    bus_access('h11, 2'b10, 16'h0000);
    cycle();
    p1_din = 8'h01;
    wait_p1_pin0_rise();
    bus_access('h11, 2'b10, 16'h0000);
    cycle();
    bus_access('h11, 2'b00, 16'h0000);
    #1;
    check_value("p1 IFG bit 0", 32'(per_dout[8]), 32'h1);
    check_value("irq_port1", 32'(irq_port1), 32'h1);
    cycle();
    bus_access('h11, 2'b10, 16'h0000);
    cycle();
    bus_access('h11, 2'b00, 16'h0000);
    #1;
    check_value("p1 IFG", 32'(per_dout[15:8]), 32'h0);
    cycle();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+logic
logic/gpio_pkg.sv
logic/gpio_reg_decode.sv
logic/gpio_pin_sampler.sv
logic/gpio_port.sv
logic/gpio_top.sv
bench/gpio_props.sv
bench/gpio_tb.sv

// File: run.sh
#!/bin/sh
# Build the GPIO testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module gpio_tb -f tb.f -o gpio_sim &&
./obj_dir/gpio_sim || exit 1
